// File: flist.f
verilog/cnn_pkg.sv
verilog/pixel_stream_if.sv
verilog/line_window.sv
verilog/conv2d_stage.sv
verilog/maxpool2d.sv
verilog/channel_sum.sv
verilog/cnn_top.sv
sim/cnn_properties.sv
sim/cnn_tb.sv

// File: sim/cnn_properties.sv
// handshake and reset assertions on the result stream of cnn_top
`default_nettype none

module cnn_properties import cnn_pkg::*; (
    input logic      clk,
    input logic      i_rst_n,
    input chan_vec_t o_data,
    input logic      o_valid,
    input logic      o_last,
    input logic      i_out_ready
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [OUT_CH*VALUE_BITS-1:0] data_bits;

    // failed assertions so far
    int failures = 0;

    always_comb begin
        for (int ch = 0; ch < OUT_CH; ch++) begin
            data_bits[ch*VALUE_BITS +: VALUE_BITS] = o_data[ch];
        end
    end

    // a stalled result holds until it is taken
    a_hold_stalled: assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_valid && !i_out_ready) |=> (o_valid && $stable(data_bits) && $stable(o_last)))
        else begin
            $error("result changed while i_out_ready was low");
            failures++;
        end

    a_idle_in_reset: assert property (@(posedge clk) !i_rst_n |-> (o_valid !== 1'b1))
        else begin
            $error("o_valid high during reset");
            failures++;
        end

    // one result per image, always the last one
    a_last_with_valid: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_valid |-> o_last)
        else begin
            $error("o_valid without o_last");
            failures++;
        end

endmodule

`default_nettype wire

// File: sim/cnn_tb.sv
// testbench for cnn_top: clock, reset, reference model, stimulus table, driver, checker, timeouts
`default_nettype none

module cnn_tb import cnn_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PIXELS     = IMG_W * IMG_W;
    localparam int MAX_IMGS   = 4;
    localparam int NUM_ROWS   = 7;
    localparam int LIMIT      = 2000;
    localparam int PAT_ZERO   = 0;
    localparam int PAT_CONST  = 1;
    localparam int PAT_RAMP   = 2;
    localparam int PAT_NEG    = 3;
    localparam int PAT_POS    = 4;
    localparam int PAT_RANDOM = 5;

    typedef struct {
        int          pattern;
        int          throttle;
        int          count;
        logic [31:0] seed;
    } test_row_t;

    // pattern, output throttle, images back to back, lcg seed
    test_row_t tests [NUM_ROWS] = '{
        '{PAT_ZERO,   0, 1, 32'd16},
        '{PAT_CONST,  0, 1, 32'd17},
        '{PAT_RAMP,   0, 1, 32'd18},
        '{PAT_NEG,    0, 1, 32'd19},
        '{PAT_POS,    0, 1, 32'd20},
        '{PAT_RANDOM, 1, 3, 32'd21},
        '{PAT_RANDOM, 0, 4, 32'd22}
    };

    logic      clk;
    logic      i_rst_n;
    value_t    i_data;
    logic      i_valid;
    logic      i_last;
    logic      o_ready;
    chan_vec_t o_data;
    logic      o_valid;
    logic      o_last;
    logic      i_out_ready;
    logic      collecting;

    value_t images   [NUM_ROWS][MAX_IMGS][PIXELS];
    longint expected [NUM_ROWS][MAX_IMGS][OUT_CH];

    cnn_top cnn_top_inst (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_data      (i_data),
        .i_valid     (i_valid),
        .i_last      (i_last),
        .o_ready     (o_ready),
        .o_data      (o_data),
        .o_valid     (o_valid),
        .o_last      (o_last),
        .i_out_ready (i_out_ready)
    );

    bind cnn_top cnn_properties cnn_properties_inst (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .o_data      (o_data),
        .o_valid     (o_valid),
        .o_last      (o_last),
        .i_out_ready (i_out_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic longint saturate(input longint v);
        longint r;
        r = v;
        if (v > 32767) begin
            r = 32767;
        end else if (v < -32768) begin
            r = -32768;
        end
        return r;
    endfunction

    task automatic fail_run();
        $display("TEST FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic signed [63:0] exp,
                               input logic signed [63:0] act);
        if (exp !== act) begin
            $display("MISMATCH at %0t: %s expected %0d got %0d", $time, name, exp, act);
            fail_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        fail_run();
    endtask

    task automatic stop_on_assertion();
        if (cnn_top_inst.cnn_properties_inst.failures != 0) begin
            $display("a result stream assertion failed before %0t", $time);
            fail_run();
        end
    endtask

    always @(negedge clk) begin
        stop_on_assertion();
    end

    task automatic build_images(input int row);
        logic [31:0] st;
        int          y;
        int          x;
        value_t      p;
        st = tests[row].seed;
        for (int n = 0; n < tests[row].count; n++) begin
            for (int idx = 0; idx < PIXELS; idx++) begin
                y = idx / IMG_W;
                x = idx % IMG_W;
                case (tests[row].pattern)
                    PAT_ZERO:  p = '0;
                    PAT_CONST: p = 16'sd384;
                    PAT_RAMP:  p = value_t'((y * IMG_W + x) * 24 - 600);
                    PAT_NEG:   p = -16'sd30000;
                    PAT_POS:   p = 16'sd32767;
                    default: begin
                        st = lcg_next(st);
                        p  = value_t'($signed(st[27:16]));
                    end
                endcase
                images[row][n][idx] = p;
            end
        end
    endtask

    // conv with Q8 rescale, bias, clamp, relu, then 2x2 max and clamped sum
    function automatic void model_image(input int row, input int n);
        longint conv [OUT_CH][CONV_W][CONV_W];
        longint acc;
        longint m;
        longint sum;
        for (int ch = 0; ch < OUT_CH; ch++) begin
            for (int y = 0; y < CONV_W; y++) begin
                for (int x = 0; x < CONV_W; x++) begin
                    acc = 0;
                    for (int r = 0; r < KERNEL; r++) begin
                        for (int c = 0; c < KERNEL; c++) begin
                            acc += longint'(images[row][n][(y + r) * IMG_W + x + c])
                                   * longint'(CONV_WEIGHT[ch][r][c]);
                        end
                    end
                    acc = saturate((acc >>> WEIGHT_FRAC) + longint'(CONV_BIAS[ch]));
                    conv[ch][y][x] = (acc < 0) ? 0 : acc;
                end
            end
            sum = 0;
            for (int py = 0; py < POOL_W; py++) begin
                for (int px = 0; px < POOL_W; px++) begin
                    m = conv[ch][2*py][2*px];
                    for (int k = 1; k < 4; k++) begin
                        if (conv[ch][2*py + k/2][2*px + k%2] > m) begin
                            m = conv[ch][2*py + k/2][2*px + k%2];
                        end
                    end
                    sum += m;
                end
            end
            expected[row][n][ch] = saturate(sum);
        end
    endfunction

    task automatic drive_images(input int row);
        int waited;
        for (int n = 0; n < tests[row].count; n++) begin
            for (int idx = 0; idx < PIXELS; idx++) begin
                i_data  <= images[row][n][idx];
                i_valid <= 1'b1;
                i_last  <= (idx == PIXELS - 1);
                waited = 0;
                @(negedge clk);
                while (!o_ready) begin
                    waited++;
                    if (waited > LIMIT) begin
                        report_timeout("o_ready on the pixel stream");
                    end
                    @(negedge clk);
                end
                @(posedge clk);
            end
        end
        i_valid <= 1'b0;
        i_last  <= 1'b0;
    endtask

    task automatic collect_results(input int row);
        int waited;
        for (int n = 0; n < tests[row].count; n++) begin
            waited = 0;
            @(negedge clk);
            while (!(o_valid && i_out_ready)) begin
                waited++;
                if (waited > LIMIT) begin
                    report_timeout("a result with o_valid and i_out_ready");
                end
                @(negedge clk);
            end
            check_value("o_last", 1, o_last);
            for (int ch = 0; ch < OUT_CH; ch++) begin
                check_value($sformatf("o_data[%0d]", ch), expected[row][n][ch], o_data[ch]);
            end
            @(posedge clk);
        end
        collecting = 1'b0;
    endtask

    // random low spans of the output ready
    task automatic throttle_ready(input int row);
        logic [31:0] st;
        int          span;
        logic        level;
        st    = tests[row].seed ^ 32'h0000_beef;
        span  = 0;
        level = 1'b1;
        while (collecting) begin
            if (tests[row].throttle != 0) begin
                if (span == 0) begin
                    st    = lcg_next(st);
                    level = st[20];
                    span  = int'(st[19:16]) + 1;
                end
                span--;
            end
            i_out_ready <= level;
            @(posedge clk);
        end
        i_out_ready <= 1'b1;
    endtask

    initial begin
        i_rst_n     = 1'b0;
        i_data      = '0;
        i_valid     = 1'b0;
        i_last      = 1'b0;
        i_out_ready = 1'b0;
        collecting  = 1'b0;
        for (int row = 0; row < NUM_ROWS; row++) begin
            build_images(row);
            for (int n = 0; n < tests[row].count; n++) begin
                model_image(row, n);
            end
        end
        repeat (4) @(posedge clk);
        i_rst_n     <= 1'b1;
        i_out_ready <= 1'b1;
        @(negedge clk);
        check_value("o_valid", 0, o_valid);
        check_value("o_ready", 1, o_ready);
        for (int row = 0; row < NUM_ROWS; row++) begin
            @(posedge clk);
            collecting = 1'b1;
            fork
                drive_images(row);
                collect_results(row);
                throttle_ready(row);
            join
            // exactly one result per image
            repeat (20) begin
                @(negedge clk);
                check_value("o_valid", 0, o_valid);
            end
        end
        stop_on_assertion();
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/channel_sum.sv
// per-channel saturating sum over the pooled image, one result per image
`default_nettype none

module channel_sum import cnn_pkg::*; (
    input  logic           clk,
    input  logic           i_rst_n,
    pixel_stream_if.sink   in,
    pixel_stream_if.source out
);

    acc_t      sums     [OUT_CH];
    acc_t      next_sum [OUT_CH];
    chan_vec_t total;
    logic      take;

    assign in.ready = !out.valid || out.ready;
    assign take     = in.valid && in.ready;

    always_comb begin
        for (int ch = 0; ch < OUT_CH; ch++) begin
            next_sum[ch] = sums[ch] + acc_t'(in.data[ch]);
            total[ch]    = clamp_value(next_sum[ch]);
        end
    end

    always_ff @(posedge clk) begin
        if (take && in.last) begin
            out.data <= total;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int ch = 0; ch < OUT_CH; ch++) begin
                sums[ch] <= '0;
            end
            out.valid <= 1'b0;
            out.last  <= 1'b0;
        end else begin
            if (take) begin
                // next image starts from zero
                for (int ch = 0; ch < OUT_CH; ch++) begin
                    sums[ch] <= in.last ? '0 : next_sum[ch];
                end
            end
            if (take && in.last) begin
                out.valid <= 1'b1;
                out.last  <= 1'b1;
            end else if (out.ready) begin
                out.valid <= 1'b0;
                out.last  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/cnn_pkg.sv
// image geometry, fixed-point formats, stream types, saturation helper, conv weights and biases
`default_nettype none

package cnn_pkg;

    // image and layer geometry
    localparam int IMG_W  = 8;
    localparam int KERNEL = 3;
    localparam int CONV_W = IMG_W - 2;
    localparam int POOL_W = CONV_W / 2;
    localparam int OUT_CH = 2;

    // Q8 data, Q8 weights
    localparam int VALUE_BITS  = 16;
    localparam int VALUE_FRAC  = 8;
    localparam int WEIGHT_FRAC = 8;
    localparam int ACC_BITS    = 40;

    typedef logic signed [VALUE_BITS-1:0] value_t;
    typedef logic signed [ACC_BITS-1:0]   acc_t;
    typedef value_t chan_vec_t [OUT_CH];
    typedef value_t window_t [KERNEL][KERNEL];

    // row 0 of each kernel is the oldest image row
    localparam value_t CONV_WEIGHT [OUT_CH][KERNEL][KERNEL] = '{
        '{'{-16'sd48, -16'sd96, -16'sd40},
          '{ 16'sd8,   16'sd160, 16'sd12},
          '{ 16'sd40,  16'sd88,  16'sd56}},
        '{'{ 16'sd16,  16'sd32,  16'sd16},
          '{ 16'sd32, -16'sd64,  16'sd32},
          '{-16'sd24,  16'sd32,  16'sd16}}
    };

    // 0.75 and -0.5
    localparam value_t CONV_BIAS [OUT_CH] = '{
        value_t'(3 <<< (VALUE_FRAC - 2)),
        value_t'(-(1 <<< (VALUE_FRAC - 1)))
    };

    // clamp a wide sum into the value range
    function automatic value_t clamp_value(input acc_t a);
        value_t result;
        if (a[ACC_BITS-1] && !(&a[ACC_BITS-2:VALUE_BITS-1])) begin
            result = {1'b1, {(VALUE_BITS-1){1'b0}}};
        end else if (!a[ACC_BITS-1] && (|a[ACC_BITS-2:VALUE_BITS-1])) begin
            result = {1'b0, {(VALUE_BITS-1){1'b1}}};
        end else begin
            result = a[VALUE_BITS-1:0];
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// File: verilog/cnn_top.sv
// top level of the feature extractor: line window, convolution, max pooling and channel sum
`default_nettype none

module cnn_top import cnn_pkg::*; (
    input  logic      clk,
    input  logic      i_rst_n,
    input  value_t    i_data,
    input  logic      i_valid,
    input  logic      i_last,
    output logic      o_ready,
    output chan_vec_t o_data,
    output logic      o_valid,
    output logic      o_last,
    input  logic      i_out_ready
);

    window_t win;
    logic    win_valid;
    logic    win_last;
    logic    win_ready;

    pixel_stream_if conv_to_pool ();
    pixel_stream_if pool_to_sum ();
    pixel_stream_if sum_to_out ();

    line_window line_window_inst (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_data      (i_data),
        .i_valid     (i_valid),
        .i_last      (i_last),
        .o_ready     (o_ready),
        .o_window    (win),
        .o_win_valid (win_valid),
        .o_win_last  (win_last),
        .i_win_ready (win_ready)
    );

    conv2d_stage conv2d_stage_inst (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_window    (win),
        .i_win_valid (win_valid),
        .i_win_last  (win_last),
        .o_win_ready (win_ready),
        .out         (conv_to_pool)
    );

    maxpool2d maxpool2d_inst (.clk(clk), .i_rst_n(i_rst_n), .in(conv_to_pool), .out(pool_to_sum));

    channel_sum channel_sum_inst (.clk(clk), .i_rst_n(i_rst_n), .in(pool_to_sum), .out(sum_to_out));

    // result stream to plain ports
    assign o_data           = sum_to_out.data;
    assign o_valid          = sum_to_out.valid;
    assign o_last           = sum_to_out.last;
    assign sum_to_out.ready = i_out_ready;

endmodule

`default_nettype wire

// File: verilog/conv2d_stage.sv
// 3x3 convolution per output channel with bias, Q8 rescale, saturation, ReLU and an output register
`default_nettype none

module conv2d_stage import cnn_pkg::*; (
    input  logic           clk,
    input  logic           i_rst_n,
    input  window_t        i_window,
    input  logic           i_win_valid,
    input  logic           i_win_last,
    output logic           o_win_ready,
    pixel_stream_if.source out
);

    acc_t      acc    [OUT_CH];
    acc_t      scaled [OUT_CH];
    chan_vec_t result;
    logic      take;

    // single output stage, refills as it drains
    assign o_win_ready = !out.valid || out.ready;
    assign take        = i_win_valid && o_win_ready;

    always_comb begin
        for (int ch = 0; ch < OUT_CH; ch++) begin
            acc[ch] = '0;
            for (int r = 0; r < KERNEL; r++) begin
                for (int c = 0; c < KERNEL; c++) begin
                    acc[ch] += acc_t'(i_window[r][c]) * acc_t'(CONV_WEIGHT[ch][r][c]);
                end
            end
            // back from Q16 products to Q8
            scaled[ch] = (acc[ch] >>> WEIGHT_FRAC) + acc_t'(CONV_BIAS[ch]);
            result[ch] = clamp_value(scaled[ch]);
            // relu
            if (result[ch] < 0) begin
                result[ch] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out.data <= result;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            out.valid <= 1'b0;
            out.last  <= 1'b0;
        end else if (take) begin
            out.valid <= 1'b1;
            out.last  <= i_win_last;
        end else if (out.ready) begin
            out.valid <= 1'b0;
            out.last  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/line_window.sv
// two-row line buffer, 3x3 window register and row/column counters of the input image
`default_nettype none

module line_window import cnn_pkg::*; (
    input  logic    clk,
    input  logic    i_rst_n,
    input  value_t  i_data,
    input  logic    i_valid,
    input  logic    i_last,
    output logic    o_ready,
    output window_t o_window,
    output logic    o_win_valid,
    output logic    o_win_last,
    input  logic    i_win_ready
);

    // last two rows, line_sr[0] is the newest pixel
    value_t line_sr [2*IMG_W];

    logic [$clog2(IMG_W)-1:0] col;
    logic [$clog2(IMG_W)-1:0] row;
    logic                     take;
    logic                     complete;

    assign o_ready  = !o_win_valid || i_win_ready;
    assign take     = i_valid && o_ready;
    assign complete = (row >= KERNEL - 1) && (col >= KERNEL - 1);

    // pixel history and window shift
    always_ff @(posedge clk) begin
        if (take) begin
            line_sr[0] <= i_data;
            for (int k = 1; k < 2*IMG_W; k++) begin
                line_sr[k] <= line_sr[k-1];
            end
            for (int r = 0; r < KERNEL; r++) begin
                for (int c = 0; c < KERNEL - 1; c++) begin
                    o_window[r][c] <= o_window[r][c+1];
                end
            end
            // new right column, top to bottom
            o_window[0][KERNEL-1] <= line_sr[2*IMG_W-1];
            o_window[1][KERNEL-1] <= line_sr[IMG_W-1];
            o_window[2][KERNEL-1] <= i_data;
        end
    end

    // position counters, cleared by last
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            col <= '0;
            row <= '0;
        end else if (take) begin
            if (i_last) begin
                col <= '0;
                row <= '0;
            end else if (col == IMG_W - 1) begin
                col <= '0;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_win_valid <= 1'b0;
            o_win_last  <= 1'b0;
        end else if (take) begin
            o_win_valid <= complete;
            o_win_last  <= i_last;
        end else if (i_win_ready) begin
            o_win_valid <= 1'b0;
            o_win_last  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/maxpool2d.sv
// 2x2 max pooling of the convolution stream with a half-row buffer of pair maxima
`default_nettype none

module maxpool2d import cnn_pkg::*; (
    input  logic           clk,
    input  logic           i_rst_n,
    pixel_stream_if.sink   in,
    pixel_stream_if.source out
);

    logic [$clog2(CONV_W)-1:0] col;
    logic [$clog2(CONV_W)-1:0] row;
    logic                      take;
    logic                      emit;

    chan_vec_t hold;
    chan_vec_t pair_buf [POOL_W];
    chan_vec_t pair_max;
    chan_vec_t pool_max;

    assign in.ready = !out.valid || out.ready;
    assign take     = in.valid && in.ready;
    // bottom right corner of a 2x2 block
    assign emit     = col[0] && row[0];

    always_comb begin
        for (int ch = 0; ch < OUT_CH; ch++) begin
            pair_max[ch] = (hold[ch] > in.data[ch]) ? hold[ch] : in.data[ch];
            pool_max[ch] = (pair_buf[col[$bits(col)-1:1]][ch] > pair_max[ch]) ?
                           pair_buf[col[$bits(col)-1:1]][ch] : pair_max[ch];
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            if (!col[0]) begin
                hold <= in.data;
            end else if (!row[0]) begin
                pair_buf[col[$bits(col)-1:1]] <= pair_max;
            end else begin
                out.data <= pool_max;
            end
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            col <= '0;
            row <= '0;
        end else if (take) begin
            if (in.last) begin
                col <= '0;
                row <= '0;
            end else if (col == CONV_W - 1) begin
                col <= '0;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            out.valid <= 1'b0;
            out.last  <= 1'b0;
        end else if (take) begin
            out.valid <= emit;
            out.last  <= in.last;
        end else if (out.ready) begin
            out.valid <= 1'b0;
            out.last  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/pixel_stream_if.sv
// valid/ready/last stream interface carrying one value per channel, with source and sink modports
`default_nettype none

interface pixel_stream_if import cnn_pkg::*; ();

    chan_vec_t data;
    logic      valid;
    logic      ready;
    logic      last;

    // data, valid and last hold until the transfer
    modport source (
        output data,
        output valid,
        output last,
        input  ready
    );

    modport sink (
        input  data,
        input  valid,
        input  last,
        output ready
    );

endinterface

`default_nettype wire
